/* Makefile */
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module femtoCoreTb

sim:
	verilator --binary --timing -Wno-fatal -f all.f --top-module femtoCoreTb \
		-Mdir obj_dir -o simv
	./obj_dir/simv 2>&1 | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* all.f */
verilog/rvPkg.sv
verilog/decodeIf.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/alu.sv
verilog/loadStoreUnit.sv
verilog/femtoCore.sv
tests/femtoCore_checker.sv
tests/femtoCoreTb.sv

/* tests/femtoCoreTb.sv */
// Random RV32E program with an ISA model; memory 16 KiB with random busy, timeout 7200 cycles
`default_nettype none

module femtoCoreTb;
  timeunit 1ns;
  timeprecision 1ps;
  import rvPkg::*;

  localparam int progLen   = 300;
  localparam int bodyStart = 30;                 // After the LUI/ADDI prologue
  localparam int bodyEnd   = 283;                // First epilogue instruction
  localparam int loopIdx   = progLen - 1;        // Self-loop JAL
  localparam int maxCycles = progLen * 12 * 2;   // 12 cycles worst case, margin 2
  localparam logic [addrWidth-1:0] loopAddr = addrWidth'(loopIdx * 4);

  logic                 clk;
  logic                 rst_n;
  logic [xlen-1:0]      memAddr;
  logic [xlen-1:0]      memWdata;
  logic [3:0]           memWmask;
  logic [xlen-1:0]      memRdata;
  logic                 memRstrb;
  logic                 memRbusy;
  logic                 memWbusy;

  logic [xlen-1:0]      mem [4096];          // 16 KiB, word indexed
  logic [xlen-1:0]      prog [progLen];      // Model's own copy of the code
  logic [15:0]          lfsr = 16'd1522;
  int                   rBusyCnt = 0;
  int                   wBusyCnt = 0;

  // ISA model state
  logic [xlen-1:0]      xr [numRegs];
  logic [addrWidth-1:0] modelPc = resetAddr;
  int                   expectKind = 0;      // 0 fetch, 1 load, 2 store
  logic [addrWidth-1:0] expAddr;
  logic [xlen-1:0]      expData;
  logic [3:0]           expMask;
  logic                 done = 1'b0;
  int                   cycles = 0;

  femtoCore dut_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .memAddr  (memAddr),
    .memWdata (memWdata),
    .memWmask (memWmask),
    .memRdata (memRdata),
    .memRstrb (memRstrb),
    .memRbusy (memRbusy),
    .memWbusy (memWbusy)
  );

  // Fibonacci LFSR x^16+x^14+x^13+x^11, one step per bit
  function automatic logic [31:0] nextBits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic failNow(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkWord(input string name, input logic [xlen-1:0] got,
                           input logic [xlen-1:0] exp);
    if (got !== exp)
      failNow($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
  endtask

  task automatic checkAddr(input string name, input logic [addrWidth-1:0] got,
                           input logic [addrWidth-1:0] exp);
    if (got !== exp)
      failNow($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
  endtask

  task automatic checkMask(input string name, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp)
      failNow($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
  endtask

  // Encoders
  function automatic instrWord encR(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    instrWord w;
    w.rType = '{f7, rs2, rs1, f3, rd, {opAluReg, 2'b11}};
    return w;
  endfunction

  function automatic instrWord encI(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] op);
    instrWord w;
    w.iType = '{imm, rs1, f3, rd, {op, 2'b11}};
    return w;
  endfunction

  function automatic instrWord encS(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    instrWord w;
    w.sType = '{imm[11:5], rs2, rs1, f3, imm[4:0], {opStore, 2'b11}};
    return w;
  endfunction

  function automatic instrWord encU(input logic [19:0] imm, input logic [4:0] rd,
      input logic [4:0] op);
    instrWord w;
    w.uType = '{imm, rd, {op, 2'b11}};
    return w;
  endfunction

  function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch, 2'b11};
  endfunction

  function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, opJal, 2'b11};
  endfunction

  function automatic logic [4:0] pickRd();
    return 5'(nextBits(4) % 14 + 1);  // x1..x14, x15 holds the data base
  endfunction

  task automatic buildProgram();
    logic [2:0] kind;
    logic [2:0] f3;
    logic [4:0] rd;
    logic [2:0] loadF3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    logic [2:0] brF3 [6]   = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    logic [11:0] off;
    prog[0] = encU(20'h00002, 5'd15, opLui);        // Data base 0x2000
    prog[1] = encI(12'h000, 5'd15, 3'd0, 5'd15, opAluImm);
    for (int r = 1; r < 15; r++)
    begin
      prog[2*r]   = encU(nextBits(20), 5'(r), opLui);
      prog[2*r+1] = encI(nextBits(12), 5'(r), 3'd0, 5'(r), opAluImm);
    end
    for (int i = bodyStart; i < bodyEnd; i++)
    begin
      kind = nextBits(3);
      rd   = pickRd();
      if ((kind == 6 || kind == 7) && i + 3 > bodyEnd)
        kind = 2;                                   // No jump past the body
      case (kind)
        0, 1:
        begin
          f3 = nextBits(3);
          prog[i] = encR((f3 == 0 || f3 == 5) ? {1'b0, nextBits(1), 5'b0} : 7'b0,
                         nextBits(5), nextBits(5), f3, rd);
        end
        2:
        begin
          f3 = nextBits(3);
          if (f3 == 1)
            off = {7'b0, 5'(nextBits(5))};          // SLLI
          else if (f3 == 5)
            off = {1'b0, 1'(nextBits(1)), 5'b0, 5'(nextBits(5))};  // SRLI, SRAI
          else
            off = nextBits(12);
          prog[i] = encI(off, nextBits(5), f3, rd, opAluImm);
        end
        3:      prog[i] = encU(nextBits(20), rd, nextBits(1) ? opLui : opAuipc);
        4:
        begin
          f3  = loadF3[nextBits(3) % 5];
          off = (f3[1:0] == 0) ? 12'(nextBits(8)) :
                (f3[1:0] == 1) ? 12'(nextBits(7)) << 1 : 12'(nextBits(6)) << 2;
          prog[i] = encI(off, 5'd15, f3, rd, opLoad);
        end
        5:
        begin
          f3  = 3'(nextBits(2) % 3);
          off = (f3 == 0) ? 12'(nextBits(8)) :
                (f3 == 1) ? 12'(nextBits(7)) << 1 : 12'(nextBits(6)) << 2;
          prog[i] = encS(off, nextBits(4), 5'd15, f3);
        end
        6:      prog[i] = encB(13'(8 + 4 * nextBits(1)), nextBits(4), nextBits(4),
                               brF3[nextBits(3) % 6]);
        default: prog[i] = encJ(21'(8 + 4 * nextBits(1)), 5'(nextBits(4) % 15));
      endcase
    end
    for (int r = 1; r < 15; r++)                    // Dump registers for checking
      prog[bodyEnd+r-1] = encS(12'(12'h400 + 4 * r), 5'(r), 5'd15, 3'd2);
    prog[297] = encI(12'(loopIdx * 4 - 1), 5'd0, 3'd0, 5'd1, opAluImm);
    prog[298] = encI(12'd2, 5'd1, 3'd0, 5'd2, opJalr);  // Odd target, bit 0 dropped
    prog[299] = encJ(21'd0, 5'd0);                  // Self-loop
  endtask

  function automatic logic [xlen-1:0] aluModel(input logic [2:0] f3, input logic [31:0] a,
      input logic [31:0] b, input logic alt);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // Executes the instruction at modelPc; loads read the memory array now
  task automatic stepModel();
    instrWord        ins;
    logic [31:0]     w;
    logic [31:0]     a;
    logic [31:0]     b;
    logic [31:0]     res;
    logic [31:0]     iImm;
    logic [31:0]     word;
    logic [2:0]      f3;
    logic            wr;
    logic            taken;
    logic [addrWidth-1:0] nextPc;
    if (modelPc[addrWidth-1:2] >= progLen)
      failNow("model PC left the program");
    ins    = prog[modelPc[addrWidth-1:2]];
    w      = ins;
    f3     = ins.rType.funct3;
    a      = xr[ins.rType.rs1[3:0]];
    b      = xr[ins.rType.rs2[3:0]];
    iImm   = {{20{w[31]}}, w[31:20]};
    nextPc = modelPc + 4;
    wr     = 1'b1;
    res    = '0;
    expectKind = 0;
    case (ins.rType.opcode[6:2])
      opLui:    res = {w[31:12], 12'b0};
      opAuipc:  res = {16'b0, 16'(modelPc + {w[15:12], 12'b0})};  // 16-bit PC adder
      opAluReg: res = aluModel(f3, a, b, w[30]);
      opAluImm: res = aluModel(f3, a, iImm, (f3 == 5) & w[30]);
      opJal:
      begin
        res    = 32'(modelPc + 16'd4);
        nextPc = modelPc + 16'({w[31], w[19:12], w[20], w[30:21], 1'b0});
      end
      opJalr:
      begin
        res    = 32'(modelPc + 16'd4);
        nextPc = 16'(a + iImm) & 16'hFFFE;
      end
      opBranch:
      begin
        wr = 1'b0;
        case (f3)
          3'd0:    taken = (a == b);
          3'd1:    taken = (a != b);
          3'd4:    taken = $signed(a) < $signed(b);
          3'd5:    taken = $signed(a) >= $signed(b);
          3'd6:    taken = a < b;
          default: taken = a >= b;
        endcase
        if (taken)
          nextPc = modelPc + 16'({{4{w[31]}}, w[7], w[30:25], w[11:8], 1'b0});
      end
      opLoad:
      begin
        expAddr    = 16'(a + iImm);
        expectKind = 1;
        word = mem[expAddr[13:2]] >> (8 * expAddr[1:0]);
        case (f3)
          3'd0:    res = {{24{word[7]}}, word[7:0]};
          3'd1:    res = {{16{word[15]}}, word[15:0]};
          3'd4:    res = {24'b0, word[7:0]};
          3'd5:    res = {16'b0, word[15:0]};
          default: res = mem[expAddr[13:2]];
        endcase
      end
      opStore:
      begin
        wr         = 1'b0;
        expAddr    = 16'(a + {{20{w[31]}}, w[31:25], w[11:7]});
        expectKind = 2;
        case (f3)
          3'd0:    expMask = 4'b0001 << expAddr[1:0];
          3'd1:    expMask = 4'b0011 << expAddr[1:0];
          default: expMask = 4'b1111;
        endcase
        expData = (f3 == 0) ? 32'(b[7:0]) << (8 * expAddr[1:0]) :
                  (f3 == 1) ? 32'(b[15:0]) << (8 * expAddr[1:0]) : b;
      end
      default:  res = '0;                              // Unknown opcode clears rd
    endcase
    if (wr && ins.rType.rd[3:0] != 0)
      xr[ins.rType.rd[3:0]] = res;
    modelPc = nextPc;
  endtask

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Memory model, registered reads and busy of 0 to 3 cycles
  always @(posedge clk)
  begin
    if (memRstrb)
    begin
      memRdata <= mem[memAddr[13:2]];
      rBusyCnt  = nextBits(2);
      memRbusy <= (rBusyCnt != 0);
    end
    else if (rBusyCnt > 0)
    begin
      rBusyCnt  = rBusyCnt - 1;
      memRbusy <= (rBusyCnt != 0);
    end
    if (memWmask != 0)
    begin
      for (int l = 0; l < 4; l++)
        if (memWmask[l])
          mem[memAddr[13:2]][8*l +: 8] <= memWdata[8*l +: 8];
      wBusyCnt  = nextBits(2);
      memWbusy <= (wBusyCnt != 0);
    end
    else if (wBusyCnt > 0)
    begin
      wBusyCnt  = wBusyCnt - 1;
      memWbusy <= (wBusyCnt != 0);
    end
  end

  // Follows the DUT's accesses against the model
  always @(posedge clk)
  begin
    if (rst_n && !done)
    begin
      if (memWmask != 0 && expectKind != 2)
        failNow("write strobe seen while no store was expected");
      if (memRstrb || memWmask != 0)                   // Zero-extended address
        checkWord("memAddr upper bits", {memAddr[xlen-1:addrWidth], {addrWidth{1'b0}}}, '0);
      if (memRstrb)
      begin
        if (expectKind == 0)
        begin
          checkAddr("memAddr (fetch)", memAddr[addrWidth-1:0], modelPc);
          if (modelPc == loopAddr)
            done = 1'b1;
          else
            stepModel();
        end
        else if (expectKind == 1)
        begin
          checkAddr("memAddr (load)", memAddr[addrWidth-1:0], expAddr);
          expectKind = 0;
        end
        else
          failNow("read strobe seen while a store was expected");
      end
      if (memWmask != 0)
      begin
        checkAddr("memAddr (store)", memAddr[addrWidth-1:0], expAddr);
        checkMask("memWmask", memWmask, expMask);
        checkWord("memWdata", memWdata & {{8{memWmask[3]}}, {8{memWmask[2]}},
                  {8{memWmask[1]}}, {8{memWmask[0]}}}, expData);
        expectKind = 0;
      end
    end
  end

  initial
  begin
    rst_n    <= 1'b0;
    memRdata <= '0;
    memRbusy <= 1'b0;
    memWbusy <= 1'b0;
    for (int i = 0; i < 4096; i++)
      mem[i] = (i * 32'h9E37_79B9) ^ {i[11:0], 20'h5A5A5};
    for (int r = 0; r < numRegs; r++)
      xr[r] = '0;
    buildProgram();
    for (int i = 0; i < progLen; i++)
      mem[i] = prog[i];
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    while (!done && cycles < maxCycles)
    begin
      @(posedge clk);
      cycles++;
    end
    if (!done)
      failNow("timeout before the program reached its final loop");
    else
    begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* tests/femtoCore_checker.sv */
// Memory-port protocol checks, bound into every femtoCore; assumes busy rises only after strobes
`default_nettype none

module femtoCore_checker (
  input logic                        clk,
  input logic                        rst_n,
  input logic [rvPkg::xlen-1:0]      memAddr,
  input logic [3:0]                  memWmask,
  input logic                        memRstrb,
  input logic                        memRbusy,
  input logic                        execState,  // High in Execute, where load strobes occur
  input logic [rvPkg::addrWidth-1:0] fetchPc     // Core PC
);
  timeunit 1ns;
  timeprecision 1ps;

  // Reads and writes never share a cycle
  noReadWithWrite: assert property (@(posedge clk) disable iff (!rst_n)
    !(memRstrb && (memWmask != 4'b0)))
    else $error("read strobe and write mask high together");

  // Write strobe lasts one cycle
  singleWrite: assert property (@(posedge clk) disable iff (!rst_n)
    (memWmask != 4'b0) |=> (memWmask == 4'b0))
    else $error("write mask nonzero in two consecutive cycles");

  // Fetches are word aligned and no PC bits get dropped
  alignedFetch: assert property (@(posedge clk) disable iff (!rst_n)
    (memRstrb && !execState) |-> (memAddr[rvPkg::addrWidth-1:0] == fetchPc))
    else $error("fetch address is not the word-aligned PC");

  stableWhileBusy: assert property (@(posedge clk) disable iff (!rst_n)
    memRbusy |-> $stable(memAddr))
    else $error("memAddr moved while the read was busy");

endmodule

bind femtoCore femtoCore_checker checker_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .memAddr   (memAddr),
  .memWmask  (memWmask),
  .memRstrb  (memRstrb),
  .memRbusy  (memRbusy),
  .execState (state[rvPkg::stExecute]),
  .fetchPc   (pc)
);

`default_nettype wire

/* verilog/alu.sv */
// Combinational; shift amount is the low 5 bits of the second operand
`default_nettype none

module alu (
  decodeIf.sink                   dec,
  input  logic [rvPkg::xlen-1:0]  rs1,
  input  logic [rvPkg::xlen-1:0]  rs2,
  output logic [rvPkg::xlen-1:0]  aluOut,     // Register write-back value
  output logic [rvPkg::xlen-1:0]  aluPlus,    // rs1 + operand, also JALR target
  output logic                    predicate   // Branch taken
);
  import rvPkg::*;

  // Mirror a word, lets one right shifter do left shifts too
  function automatic logic [xlen-1:0] bitReverse(input logic [xlen-1:0] value);
    logic [xlen-1:0] mirrored;
    for (int i = 0; i < xlen; i++)
    begin
      mirrored[i] = value[xlen-1-i];
    end
    return mirrored;
  endfunction

  logic [xlen-1:0]        aluIn2;
  logic [xlen:0]          aluMinus;   // Carry out gives unsigned borrow
  logic                   lt;
  logic                   ltu;
  logic                   eq;
  logic                   isSub;
  logic [xlen-1:0]        shiftIn;
  logic signed [xlen:0]   shiftWide;  // Extra MSB carries the SRA sign
  logic [xlen-1:0]        shifter;
  logic [xlen-1:0]        leftShift;

  // rs2 for register ops and branches, I-immediate for the rest
  assign aluIn2  = (dec.isAluReg | dec.isBranch) ? rs2 : dec.iImm;
  assign aluPlus = rs1 + aluIn2;

  // Single subtract shared by SUB and every compare
  assign aluMinus = {1'b1, ~aluIn2} + {1'b0, rs1} + {{xlen{1'b0}}, 1'b1};
  assign ltu      = aluMinus[xlen];
  assign lt       = (rs1[xlen-1] ^ aluIn2[xlen-1]) ? rs1[xlen-1] : aluMinus[xlen];
  assign eq       = (aluMinus[xlen-1:0] == '0);

  // Bit 30 also belongs to ADDI's immediate, so SUB needs the register form
  assign isSub = dec.subOrSra & dec.isAluReg;

  assign shiftIn   = dec.funct3Is[1] ? bitReverse(rs1) : rs1;  // SLL reversed
  assign shiftWide = $signed({dec.subOrSra & rs1[xlen-1], shiftIn}) >>> aluIn2[4:0];
  assign shifter   = shiftWide[xlen-1:0];
  assign leftShift = bitReverse(shifter);

  // One-hot funct3 selects one term, the others are zero
  assign aluOut =
    (dec.funct3Is[0] ? (isSub ? aluMinus[xlen-1:0] : aluPlus) : '0) |
    (dec.funct3Is[1] ? leftShift                              : '0) |
    (dec.funct3Is[2] ? {{(xlen-1){1'b0}}, lt}                 : '0) |  // SLT
    (dec.funct3Is[3] ? {{(xlen-1){1'b0}}, ltu}                : '0) |  // SLTU
    (dec.funct3Is[4] ? rs1 ^ aluIn2                           : '0) |
    (dec.funct3Is[5] ? shifter                                : '0) |  // SRL, SRA
    (dec.funct3Is[6] ? rs1 | aluIn2                           : '0) |
    (dec.funct3Is[7] ? rs1 & aluIn2                           : '0);

  // funct3 2 and 3 are not branches
  assign predicate =
    (dec.funct3Is[0] &  eq)  |  // BEQ
    (dec.funct3Is[1] & ~eq)  |  // BNE
    (dec.funct3Is[4] &  lt)  |  // BLT
    (dec.funct3Is[5] & ~lt)  |  // BGE
    (dec.funct3Is[6] &  ltu) |  // BLTU
    (dec.funct3Is[7] & ~ltu);   // BGEU

endmodule

`default_nettype wire

/* verilog/decodeIf.sv */
// Purely combinational decode of the latched instruction; valid from Execute on
`default_nettype none

interface decodeIf;
  import rvPkg::*;

  // Opcode class flags, at most one high
  logic isLoad;
  logic isAluImm;
  logic isAuipc;
  logic isStore;
  logic isAluReg;
  logic isLui;
  logic isBranch;
  logic isJalr;
  logic isJal;

  logic [7:0]            funct3Is;  // funct3Is[n] high when funct3 == n
  logic                  subOrSra;  // Instruction bit 30
  logic [xlen-1:0]       iImm;
  logic [xlen-1:0]       sImm;
  logic [xlen-1:0]       bImm;
  logic [xlen-1:0]       uImm;
  logic [xlen-1:0]       jImm;
  logic [regIdWidth-1:0] rdId;      // Low bits of rd, RV32E

  modport source (
    output isLoad, isAluImm, isAuipc, isStore, isAluReg, isLui, isBranch, isJalr, isJal,
    output funct3Is, subOrSra, iImm, sImm, bImm, uImm, jImm, rdId
  );

  modport sink (
    input isLoad, isAluImm, isAuipc, isStore, isAluReg, isLui, isBranch, isJalr, isJal,
    input funct3Is, subOrSra, iImm, sImm, bImm, uImm, jImm, rdId
  );

endinterface

`default_nettype wire

/* verilog/femtoCore.sv */
// One instruction in flight; PC, JAL/JALR links and AUIPC are addrWidth wide, zero-extended
`default_nettype none

module femtoCore (
  input  logic                    clk,
  input  logic                    rst_n,
  output logic [rvPkg::xlen-1:0]  memAddr,
  output logic [rvPkg::xlen-1:0]  memWdata,
  output logic [3:0]              memWmask,   // Nonzero for one cycle per store
  input  logic [rvPkg::xlen-1:0]  memRdata,   // Instruction and load data
  output logic                    memRstrb,   // One-cycle read strobe
  input  logic                    memRbusy,
  input  logic                    memWbusy
);
  import rvPkg::*;

  // State vector with only bit pos set
  function automatic logic [nbStates-1:0] oneHot(input int pos);
    logic [nbStates-1:0] vec;
    vec      = '0;
    vec[pos] = 1'b1;
    return vec;
  endfunction

  logic [addrWidth-1:0] pc;
  instrWord             instrQ;     // Latched instruction
  instrWord             fetched;    // memRdata viewed as an instruction
  logic [nbStates-1:0]  state;      // One-hot
  logic [xlen-1:0]      rs1;
  logic [xlen-1:0]      rs2;
  logic [xlen-1:0]      aluOut;
  logic [xlen-1:0]      aluPlus;
  logic                 predicate;
  logic [addrWidth-1:0] lsAddr;
  logic [xlen-1:0]      loadData;
  logic [xlen-1:0]      storeData;
  logic [3:0]           storeMask;
  logic                 instrDone;  // WaitInstr and word present
  logic                 memDone;
  logic                 needToWait;
  logic [addrWidth-1:0] pcPlus4;
  logic [xlen-1:0]      immSel;
  logic [addrWidth-1:0] pcPlusImm;
  logic                 jumpToPcPlusImm;
  logic [addrWidth-1:0] pcNext;
  logic [xlen-1:0]      writeBackData;
  logic                 wrEn;

  decodeIf dec ();

  instrDecoder decoder (
    .instr (instrQ),
    .dec   (dec)
  );

  // rs indices come straight from the incoming word
  regFile regs (
    .clk     (clk),
    .rdAddr1 (fetched.rType.rs1[regIdWidth-1:0]),
    .rdAddr2 (fetched.rType.rs2[regIdWidth-1:0]),
    .latch   (instrDone),
    .rs1     (rs1),
    .rs2     (rs2),
    .wrEn    (wrEn),
    .wrAddr  (dec.rdId),
    .wrData  (writeBackData)
  );

  alu aluUnit (
    .dec       (dec),
    .rs1       (rs1),
    .rs2       (rs2),
    .aluOut    (aluOut),
    .aluPlus   (aluPlus),
    .predicate (predicate)
  );

  loadStoreUnit lsu (
    .dec       (dec),
    .rs1       (rs1),
    .rs2       (rs2),
    .memRdata  (memRdata),
    .lsAddr    (lsAddr),
    .loadData  (loadData),
    .storeData (storeData),
    .storeMask (storeMask)
  );

  assign fetched    = memRdata;
  assign instrDone  = state[stWaitInstr] & ~memRbusy;
  assign memDone    = ~memRbusy & ~memWbusy;
  assign needToWait = dec.isLoad | dec.isStore;

  // Branch, JAL and AUIPC share one adder
  assign pcPlus4         = pc + addrWidth'(4);
  assign immSel          = dec.isJal ? dec.jImm : dec.isAuipc ? dec.uImm : dec.bImm;
  assign pcPlusImm       = pc + immSel[addrWidth-1:0];
  assign jumpToPcPlusImm = dec.isJal | (dec.isBranch & predicate);

  assign pcNext = dec.isJalr      ? {aluPlus[addrWidth-1:1], 1'b0} :  // Bit 0 cleared
                  jumpToPcPlusImm ? pcPlusImm :
                  pcPlus4;

  // No flag set gives zero, unknown opcodes clear rd
  assign writeBackData =
    (dec.isLui                  ? dec.uImm                                : '0) |
    (dec.isAluImm | dec.isAluReg ? aluOut                                 : '0) |
    (dec.isAuipc                ? {{(xlen-addrWidth){1'b0}}, pcPlusImm}   : '0) |
    (dec.isJal | dec.isJalr     ? {{(xlen-addrWidth){1'b0}}, pcPlus4}     : '0) |
    (dec.isLoad                 ? loadData                                : '0);

  // Non-load results in Execute, load data at the end of WaitMem
  assign wrEn = (state[stExecute] & ~dec.isLoad & ~dec.isStore & ~dec.isBranch) |
                (state[stWaitMem] & dec.isLoad & memDone);

  // Memory port
  assign memRstrb = state[stFetch] | (state[stExecute] & dec.isLoad);
  assign memWmask = {4{state[stExecute] & dec.isStore}} & storeMask;
  assign memWdata = storeData;
  assign memAddr  = (state[stFetch] | state[stWaitInstr]) ?
                    {{(xlen-addrWidth){1'b0}}, pc[addrWidth-1:2], 2'b00} :  // Word aligned
                    {{(xlen-addrWidth){1'b0}}, lsAddr};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state  <= oneHot(stWaitMem);  // Drain any write still busy
      pc     <= resetAddr;
      instrQ <= '0;
    end
    else
    begin
      unique case (1'b1)
        state[stFetch]:
        begin
          state <= oneHot(stWaitInstr);
        end
        state[stWaitInstr]:
        begin
          if (!memRbusy)
          begin
            instrQ <= fetched;  // Register reads latch in the same cycle
            state  <= oneHot(stExecute);
          end
        end
        state[stExecute]:
        begin
          pc    <= pcNext;
          state <= needToWait ? oneHot(stWaitMem) : oneHot(stFetch);
        end
        default:  // WaitMem
        begin
          if (memDone)
            state <= oneHot(stFetch);
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/instrDecoder.sv */
// Unknown opcodes raise no class flag; bits 1:0 of the word are not checked
`default_nettype none

module instrDecoder (
  input  rvPkg::instrWord instr,  // Latched instruction
  decodeIf.source         dec
);
  import rvPkg::*;

  logic [4:0] opcode;  // Major opcode, length bits dropped

  assign opcode = instr.rType.opcode[6:2];

  // Class flags
  assign dec.isLoad   = (opcode == opLoad);
  assign dec.isAluImm = (opcode == opAluImm);
  assign dec.isAuipc  = (opcode == opAuipc);
  assign dec.isStore  = (opcode == opStore);
  assign dec.isAluReg = (opcode == opAluReg);
  assign dec.isLui    = (opcode == opLui);
  assign dec.isBranch = (opcode == opBranch);
  assign dec.isJalr   = (opcode == opJalr);
  assign dec.isJal    = (opcode == opJal);

  // One-hot funct3, cheaper compares downstream
  assign dec.funct3Is = 8'b0000_0001 << instr.rType.funct3;

  assign dec.subOrSra = instr.rType.funct7[5];          // SUB and SRA/SRAI
  assign dec.rdId     = instr.rType.rd[regIdWidth-1:0];  // x16..x31 alias x0..x15

  // I-type, 12-bit signed
  assign dec.iImm = {{(xlen-12){instr.iType.imm12[11]}}, instr.iType.imm12};

  // S-type, split around rs fields
  assign dec.sImm = {{(xlen-12){instr.sType.immHi[6]}},
                     instr.sType.immHi,
                     instr.sType.immLo};

  // B-type reuses the S fields, bit 11 sits in immLo[0]
  assign dec.bImm = {{(xlen-12){instr.sType.immHi[6]}},
                     instr.sType.immLo[0],
                     instr.sType.immHi[5:0],
                     instr.sType.immLo[4:1],
                     1'b0};

  assign dec.uImm = {instr.uType.imm20, 12'b0};  // Low 12 bits always zero

  // J-type scrambled in imm20 as imm[20|10:1|11|19:12]
  assign dec.jImm = {{(xlen-20){instr.uType.imm20[19]}},
                     instr.uType.imm20[7:0],   // imm[19:12]
                     instr.uType.imm20[8],     // imm[11]
                     instr.uType.imm20[18:9],  // imm[10:1]
                     1'b0};

endmodule

`default_nettype wire

/* verilog/loadStoreUnit.sv */
// Misaligned halfword and word accesses are not trapped; lanes follow the low address bits
`default_nettype none

module loadStoreUnit (
  decodeIf.sink                        dec,
  input  logic [rvPkg::xlen-1:0]       rs1,
  input  logic [rvPkg::xlen-1:0]       rs2,
  input  logic [rvPkg::xlen-1:0]       memRdata,
  output logic [rvPkg::addrWidth-1:0]  lsAddr,
  output logic [rvPkg::xlen-1:0]       loadData,
  output logic [rvPkg::xlen-1:0]       storeData,
  output logic [3:0]                   storeMask   // Ungated, core adds Execute and store
);
  import rvPkg::*;

  logic [addrWidth-1:0] offset;
  logic                 byteAccess;  // LB, LBU, SB
  logic                 halfAccess;  // LH, LHU, SH
  logic [15:0]          loadHalf;
  logic [7:0]           loadByte;
  logic                 loadSign;

  // Separate adder from the ALU
  assign offset = dec.isStore ? dec.sImm[addrWidth-1:0] : dec.iImm[addrWidth-1:0];
  assign lsAddr = rs1[addrWidth-1:0] + offset;

  assign byteAccess = dec.funct3Is[0] | dec.funct3Is[4];
  assign halfAccess = dec.funct3Is[1] | dec.funct3Is[5];

  // Lane pick, halfword first then byte within it
  assign loadHalf = lsAddr[1] ? memRdata[31:16] : memRdata[15:0];
  assign loadByte = lsAddr[0] ? loadHalf[15:8] : loadHalf[7:0];

  // funct3 bit 2 set means unsigned
  assign loadSign = ~(|dec.funct3Is[7:4]) & (byteAccess ? loadByte[7] : loadHalf[15]);

  assign loadData = byteAccess ? {{(xlen-8){loadSign}}, loadByte}  :
                    halfAccess ? {{(xlen-16){loadSign}}, loadHalf} :
                    memRdata;

  // Replicate rs2 so every lane the mask may pick holds the right byte
  assign storeData[7:0]   = rs2[7:0];
  assign storeData[15:8]  = lsAddr[0] ? rs2[7:0] : rs2[15:8];
  assign storeData[23:16] = lsAddr[1] ? rs2[7:0] : rs2[23:16];
  assign storeData[31:24] = lsAddr[0] ? rs2[7:0]  :
                            lsAddr[1] ? rs2[15:8] : rs2[31:24];

  // 1, 2 or 4 byte enables
  assign storeMask = byteAccess ? (4'b0001 << lsAddr[1:0])              :
                     halfAccess ? (lsAddr[1] ? 4'b1100 : 4'b0011) :
                     4'b1111;

endmodule

`default_nettype wire

/* verilog/regFile.sv */
// Reads are registered on latch only; a write and a latch in one cycle is never issued
`default_nettype none

module regFile (
  input  logic                          clk,
  input  logic [rvPkg::regIdWidth-1:0]  rdAddr1,  // rs1 index
  input  logic [rvPkg::regIdWidth-1:0]  rdAddr2,  // rs2 index
  input  logic                          latch,    // Instruction accepted
  output logic [rvPkg::xlen-1:0]        rs1,
  output logic [rvPkg::xlen-1:0]        rs2,
  input  logic                          wrEn,
  input  logic [rvPkg::regIdWidth-1:0]  wrAddr,
  input  logic [rvPkg::xlen-1:0]        wrData
);
  import rvPkg::*;

  logic [xlen-1:0] regs [numRegs];  // Entry 0 never written

  // Write port, x0 stays hardwired
  always_ff @(posedge clk)
  begin
    if (wrEn && (wrAddr != '0))
      regs[wrAddr] <= wrData;
  end

  // Operand registers, held through Execute and WaitMem
  always_ff @(posedge clk)
  begin
    if (latch)
    begin
      rs1 <= (rdAddr1 == '0) ? '0 : regs[rdAddr1];
      rs2 <= (rdAddr2 == '0) ? '0 : regs[rdAddr2];
    end
  end

endmodule

`default_nettype wire

/* verilog/rvPkg.sv */
// RV32E subset without SYSTEM, RVC or M; addresses beyond addrWidth bits wrap
`default_nettype none

package rvPkg;

  // Datapath sizes
  localparam int xlen       = 32;  // Data word width
  localparam int addrWidth  = 16;  // PC and address adders
  localparam int numRegs    = 16;  // RV32E register count
  localparam int regIdWidth = 4;   // Index into the 16 registers

  localparam logic [addrWidth-1:0] resetAddr = '0;  // First fetch address

  // Major opcodes, instruction bits 6:2
  localparam logic [4:0] opLoad   = 5'b00000;  // rd <- mem[rs1+iImm]
  localparam logic [4:0] opAluImm = 5'b00100;  // rd <- rs1 OP iImm
  localparam logic [4:0] opAuipc  = 5'b00101;  // rd <- PC + uImm
  localparam logic [4:0] opStore  = 5'b01000;  // mem[rs1+sImm] <- rs2
  localparam logic [4:0] opAluReg = 5'b01100;  // rd <- rs1 OP rs2
  localparam logic [4:0] opLui    = 5'b01101;  // rd <- uImm
  localparam logic [4:0] opBranch = 5'b11000;  // if (rs1 OP rs2) PC <- PC+bImm
  localparam logic [4:0] opJalr   = 5'b11001;  // rd <- PC+4; PC <- rs1+iImm
  localparam logic [4:0] opJal    = 5'b11011;  // rd <- PC+4; PC <- PC+jImm

  // One-hot state bit positions
  localparam int stFetch     = 0;  // Read strobe on PC
  localparam int stWaitInstr = 1;  // Wait for instruction word
  localparam int stExecute   = 2;
  localparam int stWaitMem   = 3;  // Wait for load data or store completion
  localparam int nbStates    = 4;

  // Instruction formats, all over the same 32-bit word
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rTypeFields;

  typedef struct packed {
    logic [11:0] imm12;  // imm[11:0], sign in bit 11
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iTypeFields;

  typedef struct packed {
    logic [6:0] immHi;  // imm[11:5], also B-type imm[12|10:5]
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] immLo;  // imm[4:0], also B-type imm[4:1|11]
    logic [6:0] opcode;
  } sTypeFields;

  typedef struct packed {
    logic [19:0] imm20;  // U-type upper bits, J-type scrambled offset
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } uTypeFields;

  typedef union packed {
    rTypeFields rType;
    iTypeFields iType;
    sTypeFields sType;
    uTypeFields uType;
  } instrWord;

endpackage

`default_nettype wire
